// ==== compile.f ====
+incdir+logic
logic/matinv_data_pkg.sv
logic/matinv_ctrl_pkg.sv
logic/mod_arith_unit.sv
logic/matrix_loader.sv
logic/gauss_jordan_engine.sv
logic/matrix_streamer.sv
logic/matrix_inversion_top.sv
verif/matinv_tb.sv

// ==== Bender.yml ====
package:
  name: matrix_inversion

sources:
  - include_dirs:
      - logic
    files:
      - logic/matinv_data_pkg.sv
      - logic/matinv_ctrl_pkg.sv
      - logic/mod_arith_unit.sv
      - logic/matrix_loader.sv
      - logic/gauss_jordan_engine.sv
      - logic/matrix_streamer.sv
      - logic/matrix_inversion_top.sv
  - target: test
    include_dirs:
      - logic
    files:
      - verif/matinv_tb.sv

// ==== verif/matinv_tb.sv ====
//////////////////////////////////////////////////////////////////////
// Matrix inversion testbench
// Directed tests against a GF(p) Gauss-Jordan reference model
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

`include "matinv_settings.svh"

module matinv_tb;

  localparam int N  = `MATINV_N;
  localparam int NN = `MATINV_N * `MATINV_N;

  // Identity, swap, 20 random, singular, 5 stalled and 3 moduli matrices
  localparam longint NUM_MATRICES = 31;
  localparam longint WATCHDOG_NS  = NUM_MATRICES * N * N * N * `MATINV_W * 40 * 40;

  logic                   CLK;
  logic                   RST;
  matinv_data_pkg::elem_t in_data;
  logic                   in_valid;
  logic                   in_ready;
  matinv_data_pkg::elem_t modulus;
  matinv_data_pkg::elem_t out_data;
  logic                   out_valid;
  logic                   out_ready;
  logic                   out_last;
  logic                   out_singular;

  // Stimulus matrix and expected inverse, row-major
  matinv_data_pkg::elem_t mat_a   [NN];
  matinv_data_pkg::elem_t exp_inv [NN];
  logic                   exp_sing;

  logic [31:0] rng;
  int          checks;
  int          errors;

  matrix_inversion_top UUT (
    .CLK          (CLK),
    .RST          (RST),
    .in_data      (in_data),
    .in_valid     (in_valid),
    .in_ready     (in_ready),
    .modulus      (modulus),
    .out_data     (out_data),
    .out_valid    (out_valid),
    .out_ready    (out_ready),
    .out_last     (out_last),
    .out_singular (out_singular)
  );

  initial begin
    CLK = 1'b0;
    forever #20 CLK = ~CLK;
  end

  //////////////////////////////////////////////////////////////////////
  // Compare tasks
  //////////////////////////////////////////////////////////////////////

  task automatic check_elem(input string name, input matinv_data_pkg::elem_t got,
                            input matinv_data_pkg::elem_t expected);
    checks++;
    if (got !== expected) begin
      errors++;
      $display("Mismatch at %0t ns: %s got %0d expected %0d", $time, name, got, expected);
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic expected);
    checks++;
    if (got !== expected) begin
      errors++;
      $display("Mismatch at %0t ns: %s got %b expected %b", $time, name, got, expected);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic matinv_data_pkg::elem_t mod_mul(input matinv_data_pkg::elem_t a,
                                                     input matinv_data_pkg::elem_t b,
                                                     input matinv_data_pkg::elem_t p);
    matinv_data_pkg::wide_t prod;
    prod = matinv_data_pkg::wide_t'(a) * matinv_data_pkg::wide_t'(b);
    return matinv_data_pkg::elem_t'(prod % matinv_data_pkg::wide_t'(p));
  endfunction

  function automatic matinv_data_pkg::elem_t mod_sub(input matinv_data_pkg::elem_t a,
                                                     input matinv_data_pkg::elem_t b,
                                                     input matinv_data_pkg::elem_t p);
    matinv_data_pkg::wide_t sum;
    sum = matinv_data_pkg::wide_t'(a) + matinv_data_pkg::wide_t'(p)
          - matinv_data_pkg::wide_t'(b);
    return matinv_data_pkg::elem_t'(sum % matinv_data_pkg::wide_t'(p));
  endfunction

  // Modular inverse by extended Euclid
  function automatic matinv_data_pkg::elem_t mod_inv(input matinv_data_pkg::elem_t v,
                                                     input matinv_data_pkg::elem_t p);
    longint t0;
    longint t1;
    longint r0;
    longint r1;
    longint q;
    longint tmp;
    t0 = 0;
    t1 = 1;
    r0 = p;
    r1 = v;
    while (r1 != 0) begin
      q   = r0 / r1;
      tmp = t0 - q * t1;
      t0  = t1;
      t1  = tmp;
      tmp = r0 - q * r1;
      r0  = r1;
      r1  = tmp;
    end
    if (t0 < 0) begin
      t0 = t0 + p;
    end
    return matinv_data_pkg::elem_t'(t0);
  endfunction

  // Gauss-Jordan on [A | I] pivoting on the first nonzero row at or below the diagonal
  task automatic model_inverse(input matinv_data_pkg::elem_t p);
    matinv_data_pkg::elem_t aug [N][2*N];
    matinv_data_pkg::elem_t inv;
    matinv_data_pkg::elem_t f;
    matinv_data_pkg::elem_t tmp;
    int piv;
    exp_sing = 1'b0;
    for (int r = 0; r < N; r++) begin
      for (int c = 0; c < N; c++) begin
        aug[r][c]   = mat_a[r*N+c];
        aug[r][N+c] = (r == c) ? 1 : 0;
      end
    end
    for (int c = 0; c < N; c++) begin
      piv = -1;
      for (int r = c; r < N; r++) begin
        if (piv < 0 && aug[r][c] != 0) begin
          piv = r;
        end
      end
      if (piv < 0) begin
        exp_sing = 1'b1;
        return;
      end
      for (int j = 0; j < 2 * N; j++) begin
        tmp         = aug[c][j];
        aug[c][j]   = aug[piv][j];
        aug[piv][j] = tmp;
      end
      inv = mod_inv(aug[c][c], p);
      for (int j = 0; j < 2 * N; j++) begin
        aug[c][j] = mod_mul(aug[c][j], inv, p);
      end
      for (int r = 0; r < N; r++) begin
        if (r != c) begin
          f = aug[r][c];
          for (int j = 0; j < 2 * N; j++) begin
            aug[r][j] = mod_sub(aug[r][j], mod_mul(f, aug[c][j], p), p);
          end
        end
      end
    end
    for (int r = 0; r < N; r++) begin
      for (int c = 0; c < N; c++) begin
        exp_inv[r*N+c] = aug[r][N+c];
      end
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Stream drivers
  //////////////////////////////////////////////////////////////////////

  task automatic fill_random(input matinv_data_pkg::elem_t p);
    for (int k = 0; k < NN; k++) begin
      rng      = xorshift32(rng);
      mat_a[k] = matinv_data_pkg::elem_t'(rng % 32'(p));
    end
  endtask

  // Offer mat_a on the input stream with optional idle gaps
  task automatic send_matrix(input matinv_data_pkg::elem_t p, input logic gaps);
    logic accepted;
    @(posedge CLK);
    modulus <= p;
    for (int k = 0; k < NN; k++) begin
      if (gaps) begin
        rng = xorshift32(rng);
        while (rng[1:0] == 2'b00) begin
          in_valid <= 1'b0;
          @(posedge CLK);
          rng = xorshift32(rng);
        end
      end
      in_valid <= 1'b1;
      in_data  <= mat_a[k];
      accepted = 1'b0;
      // Ready sampled mid-cycle so the transfer lands on the next edge
      while (!accepted) begin
        @(negedge CLK);
        accepted = in_ready;
        @(posedge CLK);
      end
      // Modulus only counts with the first element
      if (k == 0) begin
        modulus <= '0;
      end
    end
    in_valid <= 1'b0;
  endtask

  // Collect and compare N*N outputs under optional ready stalls
  task automatic receive_matrix(input logic stalls);
    int k;
    k = 0;
    while (k < NN) begin
      @(posedge CLK);
      rng = xorshift32(rng);
      out_ready <= stalls ? (rng[1:0] != 2'b00) : 1'b1;
      @(negedge CLK);
      if (out_valid && out_ready) begin
        check_flag("out_singular", out_singular, exp_sing);
        check_flag("out_last", out_last, k == NN - 1);
        if (!exp_sing) begin
          check_elem("out_data", out_data, exp_inv[k]);
        end
        k++;
      end
    end
    @(posedge CLK);
    out_ready <= 1'b0;
  endtask

  task automatic run_matrix(input matinv_data_pkg::elem_t p, input logic gaps,
                            input logic stalls);
    model_inverse(p);
    send_matrix(p, gaps);
    receive_matrix(stalls);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Directed tests
  //////////////////////////////////////////////////////////////////////

  task automatic invert_identity();
    for (int k = 0; k < NN; k++) begin
      mat_a[k] = (k % (N + 1) == 0) ? 1 : 0;
    end
    run_matrix(16'd65521, 1'b0, 1'b0);
  endtask

  // Zero in the leading pivot forces a row swap
  task automatic swap_leading_pivot();
    mat_a[0] = 0;
    mat_a[1] = 2;
    mat_a[2] = 3;
    mat_a[3] = 1;
    mat_a[4] = 4;
    mat_a[5] = 5;
    mat_a[6] = 6;
    mat_a[7] = 0;
    mat_a[8] = 7;
    run_matrix(16'd65521, 1'b0, 1'b0);
  endtask

  task automatic invert_random_set();
    for (int i = 0; i < 20; i++) begin
      fill_random(16'd65521);
      run_matrix(16'd65521, 1'b0, 1'b0);
    end
  endtask

  // Rows 0 and 2 equal
  task automatic detect_singular();
    mat_a[0] = 3;
    mat_a[1] = 5;
    mat_a[2] = 7;
    mat_a[3] = 1;
    mat_a[4] = 2;
    mat_a[5] = 4;
    mat_a[6] = 3;
    mat_a[7] = 5;
    mat_a[8] = 7;
    run_matrix(16'd251, 1'b0, 1'b0);
  endtask

  task automatic survive_stalls();
    for (int i = 0; i < 5; i++) begin
      fill_random(16'd65521);
      run_matrix(16'd65521, 1'b1, 1'b1);
    end
  endtask

  task automatic switch_moduli();
    fill_random(16'd7);
    run_matrix(16'd7, 1'b0, 1'b0);
    fill_random(16'd251);
    run_matrix(16'd251, 1'b0, 1'b0);
    fill_random(16'd65521);
    run_matrix(16'd65521, 1'b0, 1'b0);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Main sequence and watchdog
  //////////////////////////////////////////////////////////////////////

  initial begin
    RST       = 1'b1;
    in_data   = '0;
    in_valid  = 1'b0;
    modulus   = '0;
    out_ready = 1'b0;
    rng       = 32'h8288;
    checks    = 0;
    errors    = 0;
    repeat (10) @(posedge CLK);
    RST <= 1'b0;
    @(negedge CLK);
    check_flag("in_ready", in_ready, 1'b1);
    check_flag("out_valid", out_valid, 1'b0);
    invert_identity();
    swap_leading_pivot();
    invert_random_set();
    detect_singular();
    survive_stalls();
    switch_moduli();
    repeat (4) @(posedge CLK);
    $display("Checks: %0d  Errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Timeout: tests did not complete within %0d ns", WATCHDOG_NS);
    $display("Checks: %0d  Errors: %0d", checks, errors);
    $display("ERRORS FOUND");
    $finish;
  end

endmodule

// ==== logic/matrix_inversion_top.sv ====
//////////////////////////////////////////////////////////////////////
// Matrix inversion top level
// Loader, Gauss-Jordan engine and streamer over GF(p)
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module matrix_inversion_top (
  input  logic                   CLK,
  input  logic                   RST,
  input  matinv_data_pkg::elem_t in_data,
  input  logic                   in_valid,
  output logic                   in_ready,
  input  matinv_data_pkg::elem_t modulus,
  output matinv_data_pkg::elem_t out_data,
  output logic                   out_valid,
  input  logic                   out_ready,
  output logic                   out_last,
  output logic                   out_singular
);

  // Loader to engine
  logic                   busy;
  logic                   wr_en;
  matinv_data_pkg::idx_t  wr_row;
  matinv_data_pkg::idx_t  wr_col;
  matinv_data_pkg::elem_t wr_data;
  logic                   load_done;

  // Engine to streamer
  matinv_data_pkg::idx_t  rd_row;
  matinv_data_pkg::idx_t  rd_col;
  matinv_data_pkg::elem_t rd_data;
  logic                   result_valid;
  logic                   result_singular;
  logic                   result_release;

  matrix_loader u_loader (
    .CLK       (CLK),
    .RST       (RST),
    .in_data   (in_data),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .busy      (busy),
    .wr_en     (wr_en),
    .wr_row    (wr_row),
    .wr_col    (wr_col),
    .wr_data   (wr_data),
    .load_done (load_done)
  );

  gauss_jordan_engine u_engine (
    .CLK             (CLK),
    .RST             (RST),
    .modulus         (modulus),
    .wr_en           (wr_en),
    .wr_row          (wr_row),
    .wr_col          (wr_col),
    .wr_data         (wr_data),
    .load_done       (load_done),
    .busy            (busy),
    .rd_row          (rd_row),
    .rd_col          (rd_col),
    .rd_data         (rd_data),
    .result_valid    (result_valid),
    .result_singular (result_singular),
    .result_release  (result_release)
  );

  matrix_streamer u_streamer (
    .CLK             (CLK),
    .RST             (RST),
    .result_valid    (result_valid),
    .result_singular (result_singular),
    .rd_row          (rd_row),
    .rd_col          (rd_col),
    .rd_data         (rd_data),
    .out_data        (out_data),
    .out_valid       (out_valid),
    .out_ready       (out_ready),
    .out_last        (out_last),
    .out_singular    (out_singular),
    .result_release  (result_release)
  );

endmodule

// ==== logic/matrix_streamer.sv ====
//////////////////////////////////////////////////////////////////////
// Matrix streamer
// Inverse read out in row-major order on a valid/ready stream
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

`include "matinv_settings.svh"

module matrix_streamer (
  input  logic                   CLK,
  input  logic                   RST,
  input  logic                   result_valid,
  input  logic                   result_singular,
  output matinv_data_pkg::idx_t  rd_row,
  output matinv_data_pkg::idx_t  rd_col,
  input  matinv_data_pkg::elem_t rd_data,
  output matinv_data_pkg::elem_t out_data,
  output logic                   out_valid,
  input  logic                   out_ready,
  output logic                   out_last,
  output logic                   out_singular,
  output logic                   result_release
);

  localparam matinv_data_pkg::idx_t LAST_IDX = matinv_data_pkg::idx_t'(`MATINV_N - 1);

  matinv_data_pkg::idx_t row_q;
  matinv_data_pkg::idx_t col_q;
  logic                  valid_q;
  logic                  sing_q;
  logic                  release_q;
  logic                  xfer;
  logic                  at_end;

  assign xfer   = valid_q && out_ready;
  assign at_end = (row_q == LAST_IDX) && (col_q == LAST_IDX);

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      row_q     <= '0;
      col_q     <= '0;
      valid_q   <= 1'b0;
      sing_q    <= 1'b0;
      release_q <= 1'b0;
    end else begin
      release_q <= 1'b0;
      if (result_valid) begin
        valid_q <= 1'b1;
        sing_q  <= result_singular;
      end else if (xfer) begin
        if (at_end) begin
          // Store goes back to the engine after the final element
          valid_q   <= 1'b0;
          row_q     <= '0;
          col_q     <= '0;
          release_q <= 1'b1;
        end else if (col_q == LAST_IDX) begin
          col_q <= '0;
          row_q <= row_q + 1'b1;
        end else begin
          col_q <= col_q + 1'b1;
        end
      end
    end
  end

  // Indices only move on a transfer so data holds under stall
  assign rd_row         = row_q;
  assign rd_col         = col_q;
  assign out_data       = rd_data;
  assign out_valid      = valid_q;
  assign out_last       = valid_q && at_end;
  assign out_singular   = sing_q;
  assign result_release = release_q;

  a_data_stable : assert property (@(posedge CLK) disable iff (RST)
    out_valid && !out_ready |=> $stable(out_data));

endmodule

// ==== logic/gauss_jordan_engine.sv ====
//////////////////////////////////////////////////////////////////////
// Gauss-Jordan engine
// Augmented store, pivot search, Fermat inversion and elimination
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

`include "matinv_settings.svh"

module gauss_jordan_engine (
  input  logic                   CLK,
  input  logic                   RST,
  input  matinv_data_pkg::elem_t modulus,
  input  logic                   wr_en,
  input  matinv_data_pkg::idx_t  wr_row,
  input  matinv_data_pkg::idx_t  wr_col,
  input  matinv_data_pkg::elem_t wr_data,
  input  logic                   load_done,
  output logic                   busy,
  input  matinv_data_pkg::idx_t  rd_row,
  input  matinv_data_pkg::idx_t  rd_col,
  output matinv_data_pkg::elem_t rd_data,
  output logic                   result_valid,
  output logic                   result_singular,
  input  logic                   result_release
);

  localparam int N = `MATINV_N;
  localparam int W = `MATINV_W;
  localparam int AUG_W = matinv_data_pkg::IDX_W + 1;

  localparam matinv_data_pkg::idx_t  LAST_IDX = matinv_data_pkg::idx_t'(N - 1);
  localparam logic [AUG_W-1:0]       LAST_AUG = AUG_W'(2 * N - 1);
  localparam matinv_data_pkg::elem_t ONE      = matinv_data_pkg::elem_t'(1);

  //////////////////////////////////////////////////////////////////////
  // Store and registers
  //////////////////////////////////////////////////////////////////////

  // Left half holds A, right half becomes the inverse
  matinv_data_pkg::elem_t mat [N][2*N];

  matinv_ctrl_pkg::engine_state_t state_q;
  matinv_data_pkg::idx_t          col_q;
  matinv_data_pkg::idx_t          row_q;
  logic [AUG_W-1:0]               aug_q;
  logic [1:0]                     phase_q;
  logic                           wait_q;
  logic                           result_valid_q;

  matinv_data_pkg::elem_t mod_q;
  matinv_data_pkg::elem_t exp_q;
  matinv_data_pkg::elem_t base_q;
  matinv_data_pkg::elem_t inv_q;
  matinv_data_pkg::elem_t factor_q;
  matinv_data_pkg::elem_t tmp_q;

  // Arithmetic unit hookup
  matinv_ctrl_pkg::arith_op_t au_op;
  matinv_data_pkg::elem_t     au_a;
  matinv_data_pkg::elem_t     au_b;
  matinv_data_pkg::elem_t     au_result;
  logic                       au_ready;

  logic op_needed;
  logic issue;
  logic advance;
  logic pivot_nz;

  assign pivot_nz = (mat[row_q][col_q] != '0);

  // Whether the current step needs the arithmetic unit
  always_comb begin
    case (state_q)
      matinv_ctrl_pkg::eng_invert_pivot:
        op_needed = (phase_q == 2'd0) ? exp_q[0] : (exp_q[W-1:1] != '0);
      matinv_ctrl_pkg::eng_scale_row:
        op_needed = 1'b1;
      matinv_ctrl_pkg::eng_eliminate:
        op_needed = (phase_q != 2'd0) && (row_q != col_q);
      default:
        op_needed = 1'b0;
    endcase
  end

  // Issue once, then step when the result is back
  assign issue   = op_needed && !wait_q;
  assign advance = wait_q ? au_ready : !op_needed;

  // Operand select
  always_comb begin
    au_op = matinv_ctrl_pkg::op_mul;
    au_a  = inv_q;
    au_b  = base_q;
    case (state_q)
      matinv_ctrl_pkg::eng_invert_pivot: begin
        // Squaring step
        if (phase_q == 2'd1) begin
          au_a = base_q;
        end
      end
      matinv_ctrl_pkg::eng_scale_row: begin
        au_a = mat[col_q][aug_q];
        au_b = inv_q;
      end
      matinv_ctrl_pkg::eng_eliminate: begin
        if (phase_q == 2'd2) begin
          au_op = matinv_ctrl_pkg::op_sub;
          au_a  = mat[row_q][aug_q];
          au_b  = tmp_q;
        end else begin
          au_a = factor_q;
          au_b = mat[col_q][aug_q];
        end
      end
      default: begin
      end
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // FSM
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state_q        <= matinv_ctrl_pkg::eng_idle;
      col_q          <= '0;
      row_q          <= '0;
      aug_q          <= '0;
      phase_q        <= 2'd0;
      wait_q         <= 1'b0;
      result_valid_q <= 1'b0;
    end else begin
      result_valid_q <= 1'b0;
      if (issue) begin
        wait_q <= 1'b1;
      end else if (advance) begin
        wait_q <= 1'b0;
        case (state_q)
          matinv_ctrl_pkg::eng_idle: begin
            if (load_done) begin
              state_q <= matinv_ctrl_pkg::eng_pivot_search;
              col_q   <= '0;
              row_q   <= '0;
            end
          end
          matinv_ctrl_pkg::eng_pivot_search: begin
            if (pivot_nz) begin
              state_q <= matinv_ctrl_pkg::eng_swap;
            end else if (row_q == LAST_IDX) begin
              // Column has no usable pivot
              state_q        <= matinv_ctrl_pkg::eng_singular;
              result_valid_q <= 1'b1;
            end else begin
              row_q <= row_q + 1'b1;
            end
          end
          matinv_ctrl_pkg::eng_swap: begin
            state_q <= matinv_ctrl_pkg::eng_invert_pivot;
            phase_q <= 2'd0;
          end
          matinv_ctrl_pkg::eng_invert_pivot: begin
            // Phase 0 multiplies into the result, phase 1 squares
            if (phase_q == 2'd0) begin
              phase_q <= 2'd1;
            end else if (exp_q[W-1:1] == '0) begin
              state_q <= matinv_ctrl_pkg::eng_scale_row;
              aug_q   <= '0;
              phase_q <= 2'd0;
            end else begin
              phase_q <= 2'd0;
            end
          end
          matinv_ctrl_pkg::eng_scale_row: begin
            if (aug_q == LAST_AUG) begin
              state_q <= matinv_ctrl_pkg::eng_eliminate;
              row_q   <= '0;
              aug_q   <= '0;
            end else begin
              aug_q <= aug_q + 1'b1;
            end
          end
          matinv_ctrl_pkg::eng_eliminate: begin
            // Phase 0 latches the factor, 1 multiplies, 2 subtracts
            if (row_q != col_q && phase_q == 2'd0) begin
              phase_q <= 2'd1;
            end else if (row_q != col_q && phase_q == 2'd1) begin
              phase_q <= 2'd2;
            end else if (row_q != col_q && aug_q != LAST_AUG) begin
              aug_q   <= aug_q + 1'b1;
              phase_q <= 2'd1;
            end else begin
              // Row finished or pivot row skipped
              aug_q   <= '0;
              phase_q <= 2'd0;
              if (row_q != LAST_IDX) begin
                row_q <= row_q + 1'b1;
              end else if (col_q != LAST_IDX) begin
                col_q   <= col_q + 1'b1;
                row_q   <= col_q + 1'b1;
                state_q <= matinv_ctrl_pkg::eng_pivot_search;
              end else begin
                state_q        <= matinv_ctrl_pkg::eng_done;
                result_valid_q <= 1'b1;
              end
            end
          end
          matinv_ctrl_pkg::eng_done,
          matinv_ctrl_pkg::eng_singular: begin
            // Hold the result until the streamer is through
            if (result_release) begin
              state_q <= matinv_ctrl_pkg::eng_idle;
            end
          end
          default: begin
            state_q <= matinv_ctrl_pkg::eng_idle;
          end
        endcase
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Store and payload updates
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK) begin
    if (wr_en) begin
      mat[wr_row][wr_col] <= wr_data;
      // First element opens a new matrix
      if (wr_row == '0 && wr_col == '0) begin
        mod_q <= modulus;
        for (int r = 0; r < N; r++) begin
          for (int c = 0; c < N; c++) begin
            mat[r][N+c] <= (r == c) ? ONE : '0;
          end
        end
      end
    end
    if (advance) begin
      case (state_q)
        matinv_ctrl_pkg::eng_swap: begin
          for (int j = 0; j < 2 * N; j++) begin
            mat[col_q][j] <= mat[row_q][j];
            mat[row_q][j] <= mat[col_q][j];
          end
          // Fermat exponent p-2
          exp_q  <= mod_q - 2'd2;
          base_q <= mat[row_q][col_q];
          inv_q  <= ONE;
        end
        matinv_ctrl_pkg::eng_invert_pivot: begin
          if (wait_q && phase_q == 2'd0) begin
            inv_q <= au_result;
          end else if (wait_q) begin
            base_q <= au_result;
            exp_q  <= exp_q >> 1;
          end
        end
        matinv_ctrl_pkg::eng_scale_row: begin
          mat[col_q][aug_q] <= au_result;
        end
        matinv_ctrl_pkg::eng_eliminate: begin
          if (phase_q == 2'd0) begin
            factor_q <= mat[row_q][col_q];
          end else if (wait_q && phase_q == 2'd1) begin
            tmp_q <= au_result;
          end else if (wait_q) begin
            mat[row_q][aug_q] <= au_result;
          end
        end
        default: begin
        end
      endcase
    end
  end

  assign busy            = (state_q != matinv_ctrl_pkg::eng_idle);
  assign result_valid    = result_valid_q;
  assign result_singular = (state_q == matinv_ctrl_pkg::eng_singular);
  assign rd_data         = mat[rd_row][N+rd_col];

  mod_arith_unit u_arith (
    .CLK     (CLK),
    .RST     (RST),
    .start   (issue),
    .op      (au_op),
    .a       (au_a),
    .b       (au_b),
    .modulus (mod_q),
    .result  (au_result),
    .ready   (au_ready)
  );

  // Loader holds off a new matrix until the store is released
  a_load_when_idle : assert property (@(posedge CLK) disable iff (RST)
    load_done |-> !busy);

endmodule

// ==== logic/matrix_loader.sv ====
//////////////////////////////////////////////////////////////////////
// Matrix loader
// Row-major element stream to indexed store writes
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

`include "matinv_settings.svh"

module matrix_loader (
  input  logic                   CLK,
  input  logic                   RST,
  input  matinv_data_pkg::elem_t in_data,
  input  logic                   in_valid,
  output logic                   in_ready,
  input  logic                   busy,
  output logic                   wr_en,
  output matinv_data_pkg::idx_t  wr_row,
  output matinv_data_pkg::idx_t  wr_col,
  output matinv_data_pkg::elem_t wr_data,
  output logic                   load_done
);

  localparam matinv_data_pkg::idx_t LAST_IDX = matinv_data_pkg::idx_t'(`MATINV_N - 1);

  matinv_data_pkg::idx_t row_q;
  matinv_data_pkg::idx_t col_q;
  logic                  full_q;
  logic                  busy_q;
  logic                  done_q;

  // Closed while the engine works or a full matrix waits
  assign in_ready  = !busy && !full_q;
  assign wr_en     = in_valid && in_ready;
  assign wr_row    = row_q;
  assign wr_col    = col_q;
  assign wr_data   = in_data;
  assign load_done = done_q;

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      row_q  <= '0;
      col_q  <= '0;
      full_q <= 1'b0;
      busy_q <= 1'b0;
      done_q <= 1'b0;
    end else begin
      busy_q <= busy;
      done_q <= 1'b0;
      if (wr_en) begin
        if (col_q == LAST_IDX) begin
          col_q <= '0;
          if (row_q == LAST_IDX) begin
            // Last element of the matrix
            row_q  <= '0;
            full_q <= 1'b1;
            done_q <= 1'b1;
          end else begin
            row_q <= row_q + 1'b1;
          end
        end else begin
          col_q <= col_q + 1'b1;
        end
      end else if (full_q && busy_q && !busy) begin
        // Engine released its store
        full_q <= 1'b0;
      end
    end
  end

endmodule

// ==== logic/mod_arith_unit.sv ====
//////////////////////////////////////////////////////////////////////
// Modular arithmetic unit
// Add, subtract and shift-add multiply over GF(p) with start/ready
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

`include "matinv_settings.svh"

module mod_arith_unit (
  input  logic                       CLK,
  input  logic                       RST,
  input  logic                       start,
  input  matinv_ctrl_pkg::arith_op_t op,
  input  matinv_data_pkg::elem_t     a,
  input  matinv_data_pkg::elem_t     b,
  input  matinv_data_pkg::elem_t     modulus,
  output matinv_data_pkg::elem_t     result,
  output logic                       ready
);

  localparam int W     = `MATINV_W;
  localparam int CNT_W = $clog2(W + 1);

  matinv_ctrl_pkg::arith_state_t state_q;
  matinv_ctrl_pkg::arith_op_t    op_q;
  matinv_data_pkg::elem_t        a_q;
  matinv_data_pkg::elem_t        b_q;
  matinv_data_pkg::elem_t        mod_q;
  matinv_data_pkg::elem_t        acc_q;
  matinv_data_pkg::elem_t        result_q;
  logic [CNT_W-1:0]              cnt_q;

  matinv_data_pkg::elem_t acc_dbl;
  matinv_data_pkg::elem_t addend;
  matinv_data_pkg::elem_t acc_next;
  matinv_data_pkg::elem_t addsub_res;

  // Zero extension to double width
  function automatic matinv_data_pkg::wide_t ext(input matinv_data_pkg::elem_t v);
    return {{W{1'b0}}, v};
  endfunction

  // One conditional subtract covers any x below 2p
  function automatic matinv_data_pkg::elem_t fold(input matinv_data_pkg::wide_t x,
                                                  input matinv_data_pkg::elem_t m);
    return (x >= ext(m)) ? (x[W-1:0] - m) : x[W-1:0];
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Datapath
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    // Partial sum doubled then reduced
    acc_dbl  = fold({{(W-1){1'b0}}, acc_q, 1'b0}, mod_q);
    // Multiplier bits taken MSB first
    addend   = b_q[W-1] ? a_q : '0;
    acc_next = fold(ext(acc_dbl) + ext(addend), mod_q);
    // Sub adds p first so the sum never goes negative
    if (op_q == matinv_ctrl_pkg::op_add) begin
      addsub_res = fold(ext(a_q) + ext(b_q), mod_q);
    end else begin
      addsub_res = fold(ext(a_q) + ext(mod_q) - ext(b_q), mod_q);
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Control
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state_q <= matinv_ctrl_pkg::ar_idle;
    end else if (state_q == matinv_ctrl_pkg::ar_idle) begin
      if (start) begin
        state_q <= matinv_ctrl_pkg::ar_busy;
      end
    end else if (op_q != matinv_ctrl_pkg::op_mul || cnt_q == '0) begin
      state_q <= matinv_ctrl_pkg::ar_idle;
    end
  end

  // Operand capture and iteration
  always_ff @(posedge CLK) begin
    if (start && state_q == matinv_ctrl_pkg::ar_idle) begin
      op_q  <= op;
      a_q   <= a;
      b_q   <= b;
      mod_q <= modulus;
      acc_q <= '0;
      cnt_q <= CNT_W'(W - 1);
    end else if (state_q == matinv_ctrl_pkg::ar_busy) begin
      if (op_q == matinv_ctrl_pkg::op_mul) begin
        acc_q <= acc_next;
        b_q   <= b_q << 1;
        cnt_q <= cnt_q - 1'b1;
        if (cnt_q == '0) begin
          result_q <= acc_next;
        end
      end else begin
        result_q <= addsub_res;
      end
    end
  end

  assign result = result_q;
  assign ready  = (state_q == matinv_ctrl_pkg::ar_idle);

  // Engine must wait for ready before the next start
  a_start_when_idle : assert property (@(posedge CLK) disable iff (RST)
    start |-> state_q == matinv_ctrl_pkg::ar_idle);

  // Operands already reduced by the caller
  a_operands_reduced : assert property (@(posedge CLK) disable iff (RST)
    start |-> (a < modulus) && (b < modulus));

endmodule

// ==== logic/matinv_ctrl_pkg.sv ====
//////////////////////////////////////////////////////////////////////
// Matrix inversion control types
// Arithmetic operations and FSM state encodings
//////////////////////////////////////////////////////////////////////

package matinv_ctrl_pkg;

  // Operation for the modular arithmetic unit
  typedef enum logic [1:0] {
    op_add,
    op_sub,
    op_mul
  } arith_op_t;

  // Gauss-Jordan engine FSM
  typedef enum logic [2:0] {
    eng_idle,
    eng_pivot_search,
    eng_swap,
    eng_invert_pivot,
    eng_scale_row,
    eng_eliminate,
    eng_done,
    eng_singular
  } engine_state_t;

  // Arithmetic unit FSM
  typedef enum logic {
    ar_idle,
    ar_busy
  } arith_state_t;

endpackage

// ==== logic/matinv_data_pkg.sv ====
//////////////////////////////////////////////////////////////////////
// Matrix inversion data types
// Field elements, store indices and double-width sums
//////////////////////////////////////////////////////////////////////

`include "matinv_settings.svh"

package matinv_data_pkg;

  // Index width of at least one bit even for a 1x1 matrix
  localparam int IDX_W = (`MATINV_N > 1) ? $clog2(`MATINV_N) : 1;

  // Field element or modulus
  typedef logic [`MATINV_W-1:0] elem_t;

  // Row or column index of the input matrix
  typedef logic [IDX_W-1:0] idx_t;

  // Double width for sums before reduction
  typedef logic [2*`MATINV_W-1:0] wide_t;

endpackage

// ==== logic/matinv_settings.svh ====
//////////////////////////////////////////////////////////////////////
// Matrix inversion settings
// Matrix order and element width shared by all blocks
//////////////////////////////////////////////////////////////////////

`ifndef MATINV_SETTINGS_SVH
`define MATINV_SETTINGS_SVH

// Order of the square matrix
`define MATINV_N 3

// Width of one field element and of the modulus
`define MATINV_W 16

`endif
